// ==== rtl/core_params.svh ====
// rv_pipe core parameters
// widths and reset values shared by the core and its testbench
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data path width
`define XLEN 32

// architectural registers
`define REG_COUNT 32
`define REG_IDX_W 5

// first fetch address after reset
`define RESET_PC 0

// byte address width seen on the bus
`define MEM_AW 12

`endif

// ==== rtl/isa_pkg.sv ====
// rv_pipe ISA types
// data word, register index, major opcodes and ALU operations
`include "core_params.svh"

package isa_pkg;

    // one data word
    typedef logic [`XLEN-1:0] word_t;

    // register file index
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    ////////////////////////////////
    // major opcodes, bits [6:0]
    ////////////////////////////////
    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // ALU operations after funct decode
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

endpackage

// ==== rtl/bus_pkg.sv ====
// rv_pipe bus types
// byte address, APB transfer phase and shared-bus owner
`include "core_params.svh"

package bus_pkg;

    // byte address on the shared bus
    typedef logic [`MEM_AW-1:0] addr_t;

    // APB master phase
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_phase_e;

    // who owns the current transfer
    typedef enum logic {
        FETCH,
        DATA
    } owner_e;

endpackage

// ==== rtl/reg_file.sv ====
// rv_pipe register file
// REG_COUNT words, two combinational read ports and one write port,
// x0 reads as zero and is never written
`timescale 1ns/1ps
`include "core_params.svh"

module reg_file
    import isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    output word_t    rs1_val,
    output word_t    rs2_val,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data
);

    word_t regs [`REG_COUNT];

    // write lands on the completing edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // reads see the value written on the last edge
    assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

// ==== rtl/fetch_unit.sv ====
// rv_pipe fetch stage
// holds the PC and the IF/EX instruction register, issues one fetch at a
// time and drops fetches that return after a redirect or a halt
`timescale 1ns/1ps
`include "core_params.svh"

module fetch_unit
    import isa_pkg::*, bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    output logic  fetch_req,
    output addr_t fetch_addr,
    input  logic  fetch_done,
    input  word_t rdata,
    output logic  instr_valid,
    output word_t instr,
    output addr_t instr_pc,
    input  logic  instr_taken,
    input  logic  redirect,
    input  addr_t redirect_pc,
    input  logic  halt_req
);

    addr_t pc;
    addr_t target_q;
    logic  wrong_path;
    logic  stopped;
    logic  capture;

    // the PC stays put while its fetch is on the bus
    assign fetch_addr = pc;

    // returning word is good only on the correct path and before a halt
    assign capture = fetch_done && !wrong_path && !redirect && !stopped && !halt_req;

    //////////////////////////////
    // control state
    //////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc          <= addr_t'(`RESET_PC);
            fetch_req   <= 1'b0;
            wrong_path  <= 1'b0;
            stopped     <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            // execute consumed the IR, or a branch flushed it
            if (instr_taken || redirect) begin
                instr_valid <= 1'b0;
            end
            if (halt_req) begin
                stopped <= 1'b1;
            end
            if (fetch_done) begin
                wrong_path <= 1'b0;
                if (stopped || halt_req) begin
                    // last fetch drains, nothing new goes out
                    fetch_req <= 1'b0;
                end else if (redirect) begin
                    pc <= redirect_pc;
                end else if (wrong_path) begin
                    pc <= target_q;
                end else begin
                    // next request leaves together with instr_valid
                    pc          <= pc + addr_t'(4);
                    instr_valid <= 1'b1;
                end
            end else if (redirect) begin
                // fetch in flight is stale, mark it for discard
                if (fetch_req) begin
                    wrong_path <= 1'b1;
                end else begin
                    pc <= redirect_pc;
                end
            end else if (!fetch_req && !stopped && !halt_req) begin
                fetch_req <= 1'b1;
            end
        end
    end

    // instruction register payload
    always_ff @(posedge clk) begin
        if (capture) begin
            instr    <= rdata;
            instr_pc <= pc;
        end
        if (redirect) begin
            target_q <= redirect_pc;
        end
    end

endmodule

// ==== rtl/exec_unit.sv ====
// rv_pipe decode/execute stage
// decodes the IR, runs the ALU, resolves BEQ/BNE, issues LW/SW on the
// data port and commits results to the register file
`timescale 1ns/1ps
`include "core_params.svh"

module exec_unit
    import isa_pkg::*, bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     instr_valid,
    input  word_t    instr,
    input  addr_t    instr_pc,
    output logic     instr_taken,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    input  word_t    rs1_val,
    input  word_t    rs2_val,
    output logic     wr_en,
    output reg_idx_t wr_idx,
    output word_t    wr_data,
    output logic     data_req,
    output logic     data_we,
    output addr_t    data_addr,
    output word_t    data_wdata,
    input  logic     data_done,
    input  word_t    rdata,
    output logic     redirect,
    output addr_t    redirect_pc,
    output logic     halt_req,
    output logic     halted
);

    opcode_e opcode;
    alu_op_e alu_op;
    logic [2:0] funct3;
    logic is_alu, is_load, is_store, is_branch, is_system, illegal;
    logic active;
    logic is_mem;
    logic br_taken;
    word_t imm_i, imm_s, imm_b;
    word_t alu_b, alu_res, mem_ea;

    //////////////////////////////
    // field extraction
    //////////////////////////////
    assign opcode  = opcode_e'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];
    assign wr_idx  = instr[11:7];

    // sign-extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // opcode and funct fields into unit selects
    always_comb begin
        is_alu    = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        is_system = 1'b0;
        illegal   = 1'b0;
        alu_op    = ALU_ADD;
        case (opcode)
            OP_IMM, OP_REG: begin
                is_alu = 1'b1;
                case (funct3)
                    3'b000: alu_op = (opcode == OP_REG && instr[30]) ? ALU_SUB : ALU_ADD;
                    3'b010: alu_op = ALU_SLT;
                    3'b100: alu_op = ALU_XOR;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    // shifts and SLTU are not implemented
                    default: illegal = 1'b1;
                endcase
            end
            OP_LOAD:   is_load = 1'b1;
            OP_STORE:  is_store = 1'b1;
            OP_BRANCH: begin
                is_branch = 1'b1;
                // only BEQ and BNE
                illegal = (funct3[2:1] != 2'b00);
            end
            OP_SYSTEM: is_system = 1'b1;
            default:   illegal = 1'b1;
        endcase
    end

    //////////////////////////////
    // ALU and branch compare
    //////////////////////////////
    assign alu_b = (opcode == OP_REG) ? rs2_val : imm_i;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_res = rs1_val - alu_b;
            ALU_AND: alu_res = rs1_val & alu_b;
            ALU_OR:  alu_res = rs1_val | alu_b;
            ALU_XOR: alu_res = rs1_val ^ alu_b;
            ALU_SLT: alu_res = word_t'($signed(rs1_val) < $signed(alu_b));
            default: alu_res = rs1_val + alu_b;
        endcase
    end

    // funct3[0] set means BNE
    assign br_taken = funct3[0] ? (rs1_val != rs2_val) : (rs1_val == rs2_val);

    //////////////////////////////
    // issue, memory and commit
    //////////////////////////////
    assign active = instr_valid && !halted;
    assign is_mem = is_load || is_store;

    // held until data_done since the IR and sources do not move
    assign mem_ea     = rs1_val + (is_store ? imm_s : imm_i);
    assign data_req   = active && is_mem;
    assign data_we    = is_store;
    assign data_addr  = addr_t'(mem_ea);
    assign data_wdata = rs2_val;

    // memory ops wait here until the bus answers
    assign instr_taken = active && (!is_mem || data_done);

    // x0 never gets a write strobe
    assign wr_en   = active && !illegal && (is_alu || (is_load && data_done))
                     && (wr_idx != '0);
    assign wr_data = is_load ? rdata : alu_res;

    assign redirect    = active && !illegal && is_branch && br_taken;
    assign redirect_pc = instr_pc + addr_t'(imm_b);

    // SYSTEM or anything unknown stops the core
    assign halt_req = active && (is_system || illegal);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (halt_req) begin
            halted <= 1'b1;
        end
    end

    // waiting load or store keeps its fields until data_done
    a_data_held: assert property (@(posedge clk) disable iff (rst)
        (data_req && !data_done) |=> (data_req && $stable(data_we)
                                      && $stable(data_addr) && $stable(data_wdata)));

endmodule

// ==== rtl/mem_arbiter.sv ====
// rv_pipe memory arbiter
// picks fetch or data for the single APB master, data first, and returns
// a one-cycle done with the read word to the owner
`timescale 1ns/1ps
`include "core_params.svh"

module mem_arbiter
    import isa_pkg::*, bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  fetch_req,
    input  addr_t fetch_addr,
    output logic  fetch_done,
    input  logic  data_req,
    input  logic  data_we,
    input  addr_t data_addr,
    input  word_t data_wdata,
    output logic  data_done,
    output word_t rdata,
    output logic  psel,
    output logic  penable,
    output logic  pwrite,
    output addr_t paddr,
    output word_t pwdata,
    input  word_t prdata,
    input  logic  pready
);

    apb_phase_e phase;
    owner_e     owner;
    logic       xfer_end;

    //////////////////////////////
    // phase FSM
    //////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase  <= IDLE;
            owner  <= FETCH;
            pwrite <= 1'b0;
        end else begin
            case (phase)
                IDLE: begin
                    // data wins a tie
                    if (data_req) begin
                        owner  <= DATA;
                        pwrite <= data_we;
                        phase  <= SETUP;
                    end else if (fetch_req) begin
                        owner  <= FETCH;
                        pwrite <= 1'b0;
                        phase  <= SETUP;
                    end
                end
                SETUP:   phase <= ACCESS;
                ACCESS:  if (pready) phase <= IDLE;
                default: phase <= IDLE;
            endcase
        end
    end

    // address and write data latched at grant
    always_ff @(posedge clk) begin
        if (phase == IDLE) begin
            paddr  <= data_req ? data_addr : fetch_addr;
            pwdata <= data_req ? data_wdata : '0;
        end
    end

    assign psel    = (phase != IDLE);
    assign penable = (phase == ACCESS);

    // done follows pready in the ACCESS phase
    assign xfer_end   = (phase == ACCESS) && pready;
    assign fetch_done = xfer_end && (owner == FETCH);
    assign data_done  = xfer_end && (owner == DATA);

    // only meaningful in a done cycle
    assign rdata = prdata;

    a_hold_in_wait: assert property (@(posedge clk) disable iff (rst)
        (penable && !pready) |=> ($stable(paddr) && $stable(pwrite) && $stable(pwdata)));

    // fetch side keeps its request and address until fetch_done
    a_fetch_held: assert property (@(posedge clk) disable iff (rst)
        (fetch_req && !fetch_done) |=> (fetch_req && $stable(fetch_addr)));

endmodule

// ==== rtl/rv_pipe_top.sv ====
// rv_pipe top level
// fetch and execute stages, register file and the shared APB master
`timescale 1ns/1ps
`include "core_params.svh"

module rv_pipe_top
    import isa_pkg::*, bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    output logic     psel,
    output logic     penable,
    output logic     pwrite,
    output addr_t    paddr,
    output word_t    pwdata,
    input  word_t    prdata,
    input  logic     pready,
    output logic     halted,
    output logic     commit_valid,
    output reg_idx_t commit_rd,
    output word_t    commit_data
);

    // fetch side of the arbiter
    logic     fetch_req, fetch_done;
    addr_t    fetch_addr;
    // data side of the arbiter
    logic     data_req, data_we, data_done;
    addr_t    data_addr;
    word_t    data_wdata, rdata;
    // IF/EX handoff and control back to fetch
    logic     instr_valid, instr_taken, redirect, halt_req;
    word_t    instr;
    addr_t    instr_pc, redirect_pc;
    // register read ports
    reg_idx_t rs1_idx, rs2_idx;
    word_t    rs1_val, rs2_val;

    fetch_unit u_fetch (
        .clk(clk), .rst(rst),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .fetch_done(fetch_done), .rdata(rdata),
        .instr_valid(instr_valid), .instr(instr), .instr_pc(instr_pc),
        .instr_taken(instr_taken), .redirect(redirect),
        .redirect_pc(redirect_pc), .halt_req(halt_req)
    );

    // commit outputs are the register write port itself
    exec_unit u_exec (
        .clk(clk), .rst(rst),
        .instr_valid(instr_valid), .instr(instr), .instr_pc(instr_pc),
        .instr_taken(instr_taken),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .rs1_val(rs1_val), .rs2_val(rs2_val),
        .wr_en(commit_valid), .wr_idx(commit_rd), .wr_data(commit_data),
        .data_req(data_req), .data_we(data_we),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .data_done(data_done), .rdata(rdata),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .halt_req(halt_req), .halted(halted)
    );

    reg_file u_rf (
        .clk(clk), .rst(rst),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .rs1_val(rs1_val), .rs2_val(rs2_val),
        .wr_en(commit_valid), .wr_idx(commit_rd), .wr_data(commit_data)
    );

    mem_arbiter u_arb (
        .clk(clk), .rst(rst),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_done(fetch_done),
        .data_req(data_req), .data_we(data_we), .data_addr(data_addr),
        .data_wdata(data_wdata), .data_done(data_done), .rdata(rdata),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready)
    );

endmodule

// ==== verif/apb_mem_model.sv ====
// APB memory slave for the rv_pipe testbench
// word memory with program preload, LFSR-driven wait states
// and a check on signals held during a wait
`timescale 1ns/1ps
`include "core_params.svh"

module apb_mem_model
    import isa_pkg::*, bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  psel,
    input  logic  penable,
    input  logic  pwrite,
    input  addr_t paddr,
    input  word_t pwdata,
    output word_t prdata,
    output logic  pready
);

    localparam int WORDS = 2 ** (`MEM_AW - 2);

    word_t       mem [WORDS];
    logic [31:0] lfsr = 32'h51;
    logic [1:0]  waits;
    apb_phase_e  phase_q;
    apb_phase_e  ph;
    logic        held_wait;
    addr_t       held_addr;
    logic        held_we;
    word_t       held_data;

    // write log and protocol error count, read by the testbench
    int    proto_errs;
    addr_t wr_addr;
    word_t wr_data;
    logic  wr_seen;

    // fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // unused words decode as SYSTEM, the word index sits above the opcode
    task automatic fill_pattern();
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = {13'h0, i[9:0], 2'b00, OP_SYSTEM};
        end
    endtask

    task automatic load_word(input int idx, input word_t w);
        mem[idx] = w;
    endtask

    task automatic clear_log();
        wr_seen = 1'b0;
        wr_addr = '0;
        wr_data = '0;
    endtask

    initial begin
        pready     = 1'b0;
        prdata     = '0;
        proto_errs = 0;
        wr_seen    = 1'b0;
        held_wait  = 1'b0;
        phase_q    = IDLE;
        waits      = '0;
    end

    //////////////////////////////
    // response, driven on the falling edge
    //////////////////////////////
    always @(negedge clk) begin
        if (rst) begin
            pready = 1'b0;
        end else if (psel && !penable) begin
            // two bits per transfer, one LFSR step each
            lfsr     = lfsr_next(lfsr);
            waits[0] = lfsr[0];
            lfsr     = lfsr_next(lfsr);
            waits[1] = lfsr[0];
            pready   = 1'b0;
        end else if (psel && penable) begin
            if (waits == 2'd0) begin
                pready = 1'b1;
                prdata = mem[paddr[`MEM_AW-1:2]];
            end else begin
                waits  = waits - 2'd1;
                pready = 1'b0;
            end
        end else begin
            pready = 1'b0;
        end
    end

    //////////////////////////////
    // protocol check and writes
    //////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            phase_q   = IDLE;
            held_wait = 1'b0;
        end else begin
            ph = !psel ? IDLE : (penable ? ACCESS : SETUP);
            if (held_wait && (ph != ACCESS || paddr != held_addr || pwrite != held_we
                              || pwdata != held_data)) begin
                $display("APB error: transfer signals changed during a wait state at %0t",
                         $time);
                proto_errs++;
            end
            if (ph == ACCESS && phase_q == IDLE) begin
                $display("APB error: ACCESS phase without a SETUP phase at %0t", $time);
                proto_errs++;
            end
            if (ph == ACCESS && pready && pwrite) begin
                mem[paddr[`MEM_AW-1:2]] = pwdata;
                wr_addr = paddr;
                wr_data = pwdata;
                wr_seen = 1'b1;
            end
            held_wait = (ph == ACCESS) && !pready;
            held_addr = paddr;
            held_we   = pwrite;
            held_data = pwdata;
            phase_q   = ph;
        end
    end

endmodule

// ==== verif/rv_pipe_tb.sv ====
// rv_pipe testbench
// runs a table of small programs on the core, one reset per row,
// and checks commits, store traffic, branch fetches and halt
`timescale 1ns/1ps
`include "core_params.svh"

module rv_pipe_tb
    import isa_pkg::*, bus_pkg::*;
();

    localparam int N_ROWS = 7;

    logic     clk;
    logic     rst;
    logic     psel, penable, pwrite, pready, halted, commit_valid;
    addr_t    paddr;
    word_t    pwdata, prdata, commit_data;
    reg_idx_t commit_rd;

    // stimulus and expected values, one entry per row
    string    names [N_ROWS];
    word_t    progs [N_ROWS][8];
    reg_idx_t chk_regs [N_ROWS];
    word_t    chk_vals [N_ROWS];
    int       exp_commits [N_ROWS];
    reg_idx_t last_rds [N_ROWS];
    logic     has_store [N_ROWS];
    addr_t    st_addrs [N_ROWS];
    word_t    st_datas [N_ROWS];
    logic     has_br [N_ROWS];
    addr_t    br_pcs [N_ROWS];
    addr_t    br_tgts [N_ROWS];

    // observed state
    int       err_count;
    int       commit_count;
    reg_idx_t last_rd;
    word_t    shadow [`REG_COUNT];
    addr_t    fetch_q [$];

    rv_pipe_top dut0 (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .halted(halted), .commit_valid(commit_valid),
        .commit_rd(commit_rd), .commit_data(commit_data)
    );

    apb_mem_model mem0 (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    ////////////////////////////////
    // instruction encoders
    ////////////////////////////////
    function automatic logic [2:0] funct3_of(input alu_op_e a);
        case (a)
            ALU_SLT: return 3'b010;
            ALU_XOR: return 3'b100;
            ALU_OR:  return 3'b110;
            ALU_AND: return 3'b111;
            default: return 3'b000;
        endcase
    endfunction

    function automatic word_t enc_i(input opcode_e op, input int rd, input int rs1,
                                    input logic [2:0] f3, input int imm);
        return {imm[11:0], reg_idx_t'(rs1), f3, reg_idx_t'(rd), op};
    endfunction

    function automatic word_t enc_alu_i(input alu_op_e a, input int rd, input int rs1,
                                        input int imm);
        return enc_i(OP_IMM, rd, rs1, funct3_of(a), imm);
    endfunction

    // SUB is the only op with funct7 bit 5 set
    function automatic word_t enc_r(input alu_op_e a, input int rd, input int rs1,
                                    input int rs2);
        logic [6:0] f7;
        f7 = (a == ALU_SUB) ? 7'h20 : 7'h00;
        return {f7, reg_idx_t'(rs2), reg_idx_t'(rs1), funct3_of(a), reg_idx_t'(rd), OP_REG};
    endfunction

    function automatic word_t enc_sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], reg_idx_t'(rs2), reg_idx_t'(rs1), 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t enc_lw(input int rd, input int rs1, input int imm);
        return enc_i(OP_LOAD, rd, rs1, 3'b010, imm);
    endfunction

    // bne picks funct3 000 or 001
    function automatic word_t enc_br(input logic bne, input int rs1, input int rs2,
                                     input int imm);
        return {imm[12], imm[10:5], reg_idx_t'(rs2), reg_idx_t'(rs1), {2'b00, bne},
                imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t enc_ecall();
        return {25'h0, OP_SYSTEM};
    endfunction

    ////////////////////////////////
    // compare tasks
    ////////////////////////////////
    task automatic check_word(input string tn, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", tn, exp, act);
            err_count++;
        end
    endtask

    task automatic check_reg(input string tn, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act) begin
            $display("Fail %s: expected x%0d, actual x%0d", tn, exp, act);
            err_count++;
        end
    endtask

    task automatic check_addr(input string tn, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", tn, exp, act);
            err_count++;
        end
    endtask

    task automatic set_row(input int i, input string n, input int cr, input word_t cv,
                           input int nc, input int lr);
        names[i]       = n;
        chk_regs[i]    = reg_idx_t'(cr);
        chk_vals[i]    = cv;
        exp_commits[i] = nc;
        last_rds[i]    = reg_idx_t'(lr);
        has_store[i]   = 1'b0;
        has_br[i]      = 1'b0;
    endtask

    // expected values worked out by hand from 32-bit two's complement
    task automatic build_table();
        word_t e;
        e = enc_ecall();
        progs[0] = '{enc_alu_i(ALU_ADD, 1, 0, 5), enc_alu_i(ALU_ADD, 2, 1, -7),
                     enc_alu_i(ALU_ADD, 0, 1, 3), e, e, e, e, e};
        set_row(0, "addi", 2, 32'hFFFF_FFFE, 2, 2);
        progs[1] = '{enc_alu_i(ALU_ADD, 1, 0, 100), enc_alu_i(ALU_ADD, 2, 0, -30),
                     enc_r(ALU_ADD, 3, 1, 2), enc_r(ALU_SUB, 4, 3, 1), e, e, e, e};
        set_row(1, "add_sub", 4, 32'hFFFF_FFE2, 4, 4);
        progs[2] = '{enc_alu_i(ALU_ADD, 1, 0, 12), enc_alu_i(ALU_ADD, 2, 0, 10),
                     enc_r(ALU_AND, 3, 1, 2), enc_r(ALU_OR, 4, 1, 2),
                     enc_r(ALU_XOR, 5, 3, 4), e, e, e};
        set_row(2, "and_or_xor", 5, 32'h0000_0006, 5, 5);
        progs[3] = '{enc_alu_i(ALU_ADD, 1, 0, -1), enc_alu_i(ALU_ADD, 2, 0, 1),
                     enc_r(ALU_SLT, 3, 1, 2), enc_r(ALU_SLT, 4, 2, 1),
                     enc_r(ALU_ADD, 5, 3, 3), e, e, e};
        set_row(3, "slt", 5, 32'h0000_0002, 5, 5);
        progs[4] = '{enc_alu_i(ALU_ADD, 1, 0, 256), enc_alu_i(ALU_ADD, 2, 0, -85),
                     enc_sw(2, 1, 8), enc_lw(3, 1, 8), e, e, e, e};
        set_row(4, "sw_lw", 3, 32'hFFFF_FFAB, 3, 3);
        has_store[4] = 1'b1;
        st_addrs[4]  = 12'h108;
        st_datas[4]  = 32'hFFFF_FFAB;
        // BEQ at 0x8 jumps over 0xC and 0x10 to 0x14
        progs[5] = '{enc_alu_i(ALU_ADD, 1, 0, 3), enc_alu_i(ALU_ADD, 2, 0, 3),
                     enc_br(1'b0, 1, 2, 12), enc_alu_i(ALU_ADD, 3, 0, 99),
                     enc_alu_i(ALU_ADD, 3, 0, 77), enc_alu_i(ALU_ADD, 4, 1, 1), e, e};
        set_row(5, "beq_taken", 3, 32'h0000_0000, 3, 4);
        has_br[5]  = 1'b1;
        br_pcs[5]  = 12'h008;
        br_tgts[5] = 12'h014;
        progs[6] = '{enc_alu_i(ALU_ADD, 1, 0, 5), enc_alu_i(ALU_ADD, 2, 0, 5),
                     enc_br(1'b1, 1, 2, 8), enc_alu_i(ALU_ADD, 3, 0, 7), e, e, e, e};
        set_row(6, "bne_not_taken", 3, 32'h0000_0007, 3, 3);
    endtask

    // commit and fetch monitor, sampled on the rising edge
    always @(posedge clk) begin
        if (rst) begin
            commit_count = 0;
            last_rd = '0;
            fetch_q.delete();
            for (int i = 0; i < `REG_COUNT; i++) begin
                shadow[i] = '0;
            end
        end else begin
            if (commit_valid) begin
                commit_count++;
                shadow[commit_rd] = commit_data;
                last_rd = commit_rd;
            end
            if (psel && !penable && !pwrite) begin
                fetch_q.push_back(paddr);
            end
        end
    end

    // first fetch after the branch that is not the skipped slot
    task automatic check_branch(input int r);
        int k;
        int j;
        k = -1;
        j = -1;
        for (int i = 0; i < fetch_q.size(); i++) begin
            if (k < 0 && fetch_q[i] == br_pcs[r]) begin
                k = i;
            end else if (k >= 0 && j < 0 && fetch_q[i] != br_pcs[r] + addr_t'(4)) begin
                j = i;
            end
        end
        if (j < 0) begin
            $display("%s: no fetch seen after the branch", names[r]);
            err_count++;
        end else begin
            check_addr(names[r], br_tgts[r], fetch_q[j]);
        end
    endtask

    task automatic run_row(input int r);
        logic seen_idle;
        logic late_xfer;
        @(negedge clk);
        rst = 1'b1;
        mem0.fill_pattern();
        for (int i = 0; i < 8; i++) begin
            mem0.load_word(i, progs[r][i]);
        end
        mem0.clear_log();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        if (psel || penable || commit_valid || halted) begin
            $display("%s: bus or commit outputs not idle after reset", names[r]);
            err_count++;
        end
        while (!psel) @(negedge clk);
        check_addr(names[r], addr_t'(`RESET_PC), paddr);
        while (!halted) @(negedge clk);
        // in-flight fetch may drain, nothing new may start
        seen_idle = 1'b0;
        late_xfer = 1'b0;
        repeat (16) begin
            @(negedge clk);
            if (!halted) begin
                $display("%s: halted dropped before reset", names[r]);
                err_count++;
            end
            if (!psel) begin
                seen_idle = 1'b1;
            end else if (seen_idle && !late_xfer) begin
                $display("%s: APB transfer started after halt", names[r]);
                err_count++;
                late_xfer = 1'b1;
            end
        end
        check_word(names[r], chk_vals[r], shadow[chk_regs[r]]);
        check_word(names[r], word_t'(exp_commits[r]), word_t'(commit_count));
        check_reg(names[r], last_rds[r], last_rd);
        if (has_store[r]) begin
            if (!mem0.wr_seen) begin
                $display("%s: no APB write seen for the store", names[r]);
                err_count++;
            end
            check_addr(names[r], st_addrs[r], mem0.wr_addr);
            check_word(names[r], st_datas[r], mem0.wr_data);
        end
        if (has_br[r]) begin
            check_branch(r);
        end
    endtask

    ////////////////////////////////
    // main sequence
    ////////////////////////////////
    initial begin
        rst = 1'b1;
        err_count = 0;
        build_table();
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        $display("errors: %0d check, %0d protocol", err_count, mem0.proto_errs);
        if (err_count == 0 && mem0.proto_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog, 8 words per row at up to 40 cycles each
    initial begin
        repeat (N_ROWS * 8 * 40) @(posedge clk);
        $display("watchdog expired before all rows finished");
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== rv_pipe.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/bus_pkg.sv
rtl/reg_file.sv
rtl/fetch_unit.sv
rtl/exec_unit.sv
rtl/mem_arbiter.sv
rtl/rv_pipe_top.sv
verif/apb_mem_model.sv
verif/rv_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rv_pipe testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv_pipe.f --top-module rv_pipe_tb -o rv_pipe_sim
./obj_dir/rv_pipe_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
